/* common/axi_b_config.svh */
`ifndef AXI_B_CONFIG_SVH
`define AXI_B_CONFIG_SVH

// Crossbar size
`define AXI_NUM_MST 3
`define AXI_NUM_SLV 7

// Master-side ID, and the master index the crossbar puts on top of it
`define AXI_ID_BITS 4
`define AXI_MST_BITS 2
`define AXI_IDS_BITS 6  // AXI_MST_BITS + AXI_ID_BITS

// BRESP encodings
`define AXI_RESP_BITS 2
`define AXI_RESP_OKAY 2'b00
`define AXI_RESP_EXOKAY 2'b01
`define AXI_RESP_SLVERR 2'b10
`define AXI_RESP_DECERR 2'b11

// Outstanding write bursts still waiting for a B response
`define AXI_PEND_BITS 4

`endif

/* common/axi_b_pkg.sv */
`default_nettype none

package axi_b_pkg;

  `include "axi_b_config.svh"

  // One bit per slave, top bit is idle
  typedef enum logic [`AXI_NUM_SLV:0] {
    LOCK_S0 = 8'b0000_0001,
    LOCK_S1 = 8'b0000_0010,
    LOCK_S2 = 8'b0000_0100,
    LOCK_S3 = 8'b0000_1000,
    LOCK_S4 = 8'b0001_0000,
    LOCK_S5 = 8'b0010_0000,
    LOCK_S6 = 8'b0100_0000,
    LOCK_NO = 8'b1000_0000
  } b_lock_e;

  typedef enum logic [`AXI_RESP_BITS-1:0] {
    RESP_OKAY   = `AXI_RESP_OKAY,
    RESP_EXOKAY = `AXI_RESP_EXOKAY,
    RESP_SLVERR = `AXI_RESP_SLVERR,
    RESP_DECERR = `AXI_RESP_DECERR
  } b_resp_e;

  // Slave-side BID, either raw or split into master index and local ID
  typedef union packed {
    logic [`AXI_IDS_BITS-1:0] raw;
    struct packed {
      logic [`AXI_MST_BITS-1:0] mst;  // Issuing master
      logic [`AXI_ID_BITS-1:0]  id;   // Master's own AWID
    } fld;
  } b_ids_u;

endpackage

`default_nettype wire

/* hw/b_channel/b_pending_counter.sv */
`default_nettype none
`timescale 1ns/1ps

`include "axi_b_config.svh"

module b_pending_counter (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic [`AXI_NUM_MST-1:0] wvalid_m,
  input  logic [`AXI_NUM_MST-1:0] wready_m,
  input  logic [`AXI_NUM_MST-1:0] wlast_m,
  input  logic                    b_handshake,
  output logic                    pending
);

  logic [`AXI_PEND_BITS-1:0] count;
  logic [`AXI_PEND_BITS-1:0] count_next;
  logic [`AXI_PEND_BITS-1:0] done_cnt;   // Bursts closed this cycle
  logic [`AXI_PEND_BITS-1:0] resp_cnt;

  // Several masters may accept their last W beat in the same cycle
  always_comb begin
    done_cnt = '0;
    for (int i = 0; i < `AXI_NUM_MST; i++) begin
      if (wvalid_m[i] && wready_m[i] && wlast_m[i]) begin
        done_cnt = done_cnt + 1'b1;
      end
    end
  end

  assign resp_cnt   = {{(`AXI_PEND_BITS-1){1'b0}}, b_handshake};
  assign count_next = count + done_cnt - resp_cnt;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      count <= '0;
    end else begin
      count <= count_next;
    end
  end

  assign pending = (count != '0);  // Registered, one cycle behind WLAST

  // A response can only retire a burst that was counted before
  a_no_resp_when_empty: assert property (
    @(posedge clk) disable iff (!rstn)
    b_handshake |-> (count != '0)
  ) else $error("B handshake with no write burst outstanding");

endmodule

`default_nettype wire

/* hw/b_channel/b_arb_fsm.sv */
`default_nettype none
`timescale 1ns/1ps

`include "axi_b_config.svh"

module b_arb_fsm (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic [`AXI_NUM_SLV-1:0] bvalid_s,
  input  logic                    pending,
  input  logic                    sel_ready,
  output axi_b_pkg::b_lock_e      lock
);

  axi_b_pkg::b_lock_e lock_next;

  logic [`AXI_NUM_SLV-1:0] slv_cur;   // Slave bits of the lock
  logic [`AXI_NUM_SLV-1:0] above;     // Valid slaves after the current one
  logic [`AXI_NUM_SLV-1:0] below;     // Valid slaves before it, wrap-around

  // Isolates the lowest set bit
  function automatic logic [`AXI_NUM_SLV-1:0] first_one(
    input logic [`AXI_NUM_SLV-1:0] vec
  );
    first_one = vec & (~vec + 1'b1);
  endfunction

  assign slv_cur = lock[`AXI_NUM_SLV-1:0];
  assign above   = bvalid_s & ~((slv_cur << 1) - 1'b1);
  assign below   = bvalid_s & (slv_cur - 1'b1);

  always_comb begin
    lock_next = lock;
    if (lock == axi_b_pkg::LOCK_NO) begin
      // Leave idle by fixed priority, lowest slave first
      if (pending && (|bvalid_s)) begin
        lock_next = axi_b_pkg::b_lock_e'({1'b0, first_one(bvalid_s)});
      end
    end else if (sel_ready) begin
      if (|above) begin
        lock_next = axi_b_pkg::b_lock_e'({1'b0, first_one(above)});
      end else if (|below) begin
        lock_next = axi_b_pkg::b_lock_e'({1'b0, first_one(below)});
      end else begin
        lock_next = axi_b_pkg::LOCK_NO;  // Nobody else waiting
      end
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      lock <= axi_b_pkg::LOCK_NO;
    end else begin
      lock <= lock_next;
    end
  end

  a_lock_onehot: assert property (
    @(posedge clk) disable iff (!rstn)
    $onehot(lock)
  ) else $error("B lock is not one-hot");

endmodule

`default_nettype wire

/* hw/b_channel/b_resp_mux.sv */
`default_nettype none
`timescale 1ns/1ps

`include "axi_b_config.svh"

module b_resp_mux (
  input  axi_b_pkg::b_lock_e                                lock,
  input  logic [`AXI_NUM_SLV-1:0][`AXI_IDS_BITS-1:0]         bid_s,
  input  logic [`AXI_NUM_SLV-1:0][`AXI_RESP_BITS-1:0]        bresp_s,
  input  logic [`AXI_NUM_SLV-1:0]                           bvalid_s,
  input  logic                                              sel_ready,
  output logic                                              sel_valid,
  output axi_b_pkg::b_ids_u                                 sel_id,
  output axi_b_pkg::b_resp_e                                sel_resp,
  output logic [`AXI_NUM_SLV-1:0]                           bready_s
);

  always_comb begin
    // Idle defaults
    sel_valid  = 1'b0;
    sel_id.raw = '0;
    sel_resp   = axi_b_pkg::RESP_SLVERR;
    bready_s   = '0;
    for (int i = 0; i < `AXI_NUM_SLV; i++) begin
      if (lock[i]) begin
        sel_valid   = bvalid_s[i];
        sel_id.raw  = bid_s[i];
        sel_resp    = axi_b_pkg::b_resp_e'(bresp_s[i]);
        bready_s[i] = sel_ready;  // Only the locked slave sees ready
      end
    end
  end

endmodule

`default_nettype wire

/* hw/b_channel/b_master_route.sv */
`default_nettype none
`timescale 1ns/1ps

`include "axi_b_config.svh"

module b_master_route (
  input  logic                                         sel_valid,
  input  axi_b_pkg::b_ids_u                            sel_id,
  input  axi_b_pkg::b_resp_e                           sel_resp,
  input  logic [`AXI_NUM_MST-1:0]                      bready_m,
  output logic [`AXI_NUM_MST-1:0][`AXI_ID_BITS-1:0]    bid_m,
  output logic [`AXI_NUM_MST-1:0][`AXI_RESP_BITS-1:0]  bresp_m,
  output logic [`AXI_NUM_MST-1:0]                      bvalid_m,
  output logic                                         sel_ready
);

  always_comb begin
    bid_m     = '0;
    bresp_m   = {`AXI_NUM_MST{axi_b_pkg::RESP_SLVERR}};
    bvalid_m  = '0;
    // No such master, so the response is taken and dropped
    sel_ready = 1'b1;
    for (int j = 0; j < `AXI_NUM_MST; j++) begin
      if (sel_id.fld.mst == j) begin
        bid_m[j]    = sel_id.fld.id;  // Master index stripped
        bresp_m[j]  = sel_resp;
        bvalid_m[j] = sel_valid;
        sel_ready   = bready_m[j];
      end
    end
  end

endmodule

`default_nettype wire

/* hw/b_channel/b_channel.sv */
`default_nettype none
`timescale 1ns/1ps

`include "axi_b_config.svh"

module b_channel (
  input  logic                                         clk,
  input  logic                                         rstn,
  // Master side
  output logic [`AXI_NUM_MST-1:0][`AXI_ID_BITS-1:0]    bid_m,
  output logic [`AXI_NUM_MST-1:0][`AXI_RESP_BITS-1:0]  bresp_m,
  output logic [`AXI_NUM_MST-1:0]                      bvalid_m,
  input  logic [`AXI_NUM_MST-1:0]                      bready_m,
  input  logic [`AXI_NUM_MST-1:0]                      wvalid_m,
  input  logic [`AXI_NUM_MST-1:0]                      wready_m,
  input  logic [`AXI_NUM_MST-1:0]                      wlast_m,
  // Slave side
  input  logic [`AXI_NUM_SLV-1:0][`AXI_IDS_BITS-1:0]    bid_s,
  input  logic [`AXI_NUM_SLV-1:0][`AXI_RESP_BITS-1:0]   bresp_s,
  input  logic [`AXI_NUM_SLV-1:0]                      bvalid_s,
  output logic [`AXI_NUM_SLV-1:0]                      bready_s
);

  logic               pending;
  logic               b_handshake;
  axi_b_pkg::b_lock_e lock;
  logic               sel_valid;
  logic               sel_ready;
  axi_b_pkg::b_ids_u  sel_id;
  axi_b_pkg::b_resp_e sel_resp;

  assign b_handshake = sel_valid & sel_ready;  // Response delivered or dropped

  b_pending_counter u_pending_counter (
    .clk         (clk),
    .rstn        (rstn),
    .wvalid_m    (wvalid_m),
    .wready_m    (wready_m),
    .wlast_m     (wlast_m),
    .b_handshake (b_handshake),
    .pending     (pending)
  );

  b_arb_fsm u_arb_fsm (
    .clk       (clk),
    .rstn      (rstn),
    .bvalid_s  (bvalid_s),
    .pending   (pending),
    .sel_ready (sel_ready),
    .lock      (lock)
  );

  b_resp_mux u_resp_mux (
    .lock      (lock),
    .bid_s     (bid_s),
    .bresp_s   (bresp_s),
    .bvalid_s  (bvalid_s),
    .sel_ready (sel_ready),
    .sel_valid (sel_valid),
    .sel_id    (sel_id),
    .sel_resp  (sel_resp),
    .bready_s  (bready_s)
  );

  b_master_route u_master_route (
    .sel_valid (sel_valid),
    .sel_id    (sel_id),
    .sel_resp  (sel_resp),
    .bready_m  (bready_m),
    .bid_m     (bid_m),
    .bresp_m   (bresp_m),
    .bvalid_m  (bvalid_m),
    .sel_ready (sel_ready)
  );

endmodule

`default_nettype wire

/* verif/tb_b_channel.sv */
`default_nettype none
`timescale 1ns/1ps

`include "axi_b_config.svh"

module tb_b_channel;

  localparam int NO_MST = `AXI_NUM_MST;  // No master bvalid expected

  typedef struct {
    logic [`AXI_NUM_MST-1:0] wdone;    // Masters closing a W burst
    logic [`AXI_NUM_SLV-1:0] bvalid;
    logic [`AXI_NUM_MST-1:0] bready;
    int                      exp_mst;
    int                      exp_slv;  // Slave whose response is shown
    logic [`AXI_NUM_SLV-1:0] exp_rdy;
  } step_t;

  logic                                        clk;
  logic                                        rstn;
  logic [`AXI_NUM_MST-1:0][`AXI_ID_BITS-1:0]   bid_m;
  logic [`AXI_NUM_MST-1:0][`AXI_RESP_BITS-1:0] bresp_m;
  logic [`AXI_NUM_MST-1:0]                     bvalid_m;
  logic [`AXI_NUM_MST-1:0]                     bready_m;
  logic [`AXI_NUM_MST-1:0]                     wvalid_m;
  logic [`AXI_NUM_MST-1:0]                     wready_m;
  logic [`AXI_NUM_MST-1:0]                     wlast_m;
  logic [`AXI_NUM_SLV-1:0][`AXI_IDS_BITS-1:0]  bid_s;
  logic [`AXI_NUM_SLV-1:0][`AXI_RESP_BITS-1:0] bresp_s;
  logic [`AXI_NUM_SLV-1:0]                     bvalid_s;
  logic [`AXI_NUM_SLV-1:0]                     bready_s;

  axi_b_pkg::b_ids_u  slv_id   [`AXI_NUM_SLV];
  axi_b_pkg::b_resp_e slv_resp [`AXI_NUM_SLV];

  step_t  steps[$];
  integer seed = 27;
  int     cycle_cnt = 0;
  int     cycle_limit;

  b_channel UUT (
    .clk      (clk),
    .rstn     (rstn),
    .bid_m    (bid_m),
    .bresp_m  (bresp_m),
    .bvalid_m (bvalid_m),
    .bready_m (bready_m),
    .wvalid_m (wvalid_m),
    .wready_m (wready_m),
    .wlast_m  (wlast_m),
    .bid_s    (bid_s),
    .bresp_s  (bresp_s),
    .bvalid_s (bvalid_s),
    .bready_s (bready_s)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      abort_run($sformatf("Timeout: the test did not end within %0d cycles", cycle_limit));
    end
  end

  task automatic check_valid(input string name, input int idx,
                             input logic [`AXI_NUM_MST-1:0] exp,
                             input logic [`AXI_NUM_MST-1:0] got);
    if (exp !== got) begin
      abort_run($sformatf("Fail %s at step %0d: expected 0x%h, got 0x%h", name, idx, exp, got));
    end
  endtask

  task automatic check_ready(input string name, input int idx,
                             input logic [`AXI_NUM_SLV-1:0] exp,
                             input logic [`AXI_NUM_SLV-1:0] got);
    if (exp !== got) begin
      abort_run($sformatf("Fail %s at step %0d: expected 0x%h, got 0x%h", name, idx, exp, got));
    end
  endtask

  task automatic check_id(input string name, input int idx,
                          input logic [`AXI_ID_BITS-1:0] exp,
                          input logic [`AXI_ID_BITS-1:0] got);
    if (exp !== got) begin
      abort_run($sformatf("Fail %s at step %0d: expected 0x%h, got 0x%h", name, idx, exp, got));
    end
  endtask

  task automatic check_resp(input string name, input int idx,
                            input axi_b_pkg::b_resp_e exp,
                            input axi_b_pkg::b_resp_e got);
    if (exp !== got) begin
      abort_run($sformatf("Fail %s at step %0d: expected 0x%h, got 0x%h", name, idx, exp, got));
    end
  endtask

  // Fixed slave IDs and responses, local IDs random
  task automatic build_slaves();
    int                 mst_of  [`AXI_NUM_SLV];
    axi_b_pkg::b_resp_e resp_of [`AXI_NUM_SLV];
    int                 rnd;
    mst_of  = '{0, 1, 2, 0, 1, 3, 2};  // Slave 5 points at no master
    resp_of = '{axi_b_pkg::RESP_OKAY, axi_b_pkg::RESP_EXOKAY, axi_b_pkg::RESP_SLVERR,
                axi_b_pkg::RESP_DECERR, axi_b_pkg::RESP_OKAY, axi_b_pkg::RESP_OKAY,
                axi_b_pkg::RESP_EXOKAY};
    for (int k = 0; k < `AXI_NUM_SLV; k++) begin
      rnd                = $random(seed);
      slv_id[k].fld.mst  = mst_of[k][`AXI_MST_BITS-1:0];
      slv_id[k].fld.id   = rnd[`AXI_ID_BITS-1:0];
      slv_resp[k]        = resp_of[k];
      bid_s[k]           = slv_id[k].raw;
      bresp_s[k]         = resp_of[k];
    end
  endtask

  task automatic add_row(input logic [`AXI_NUM_MST-1:0] wdone,
                         input logic [`AXI_NUM_SLV-1:0] bvalid,
                         input logic [`AXI_NUM_MST-1:0] bready,
                         input int exp_mst, input int exp_slv,
                         input logic [`AXI_NUM_SLV-1:0] exp_rdy);
    step_t st;
    st.wdone   = wdone;
    st.bvalid  = bvalid;
    st.bready  = bready;
    st.exp_mst = exp_mst;
    st.exp_slv = exp_slv;
    st.exp_rdy = exp_rdy;
    steps.push_back(st);
  endtask

  task automatic build_steps();
    // Slave valid but nothing outstanding
    add_row(3'b000, 7'b0000000, 3'b111, NO_MST, 0, 7'b0000000);
    add_row(3'b000, 7'b0000100, 3'b111, NO_MST, 0, 7'b0000000);
    add_row(3'b000, 7'b0000100, 3'b111, NO_MST, 0, 7'b0000000);
    // One burst, slave 2 to master 2 two cycles later
    add_row(3'b001, 7'b0000100, 3'b111, NO_MST, 0, 7'b0000000);
    add_row(3'b000, 7'b0000100, 3'b111, NO_MST, 0, 7'b0000000);
    add_row(3'b000, 7'b0000100, 3'b111, 2,      2, 7'b0000100);
    add_row(3'b000, 7'b0000000, 3'b111, NO_MST, 0, 7'b0000000);
    // Master 1 stalls slave 4
    add_row(3'b010, 7'b0010000, 3'b111, NO_MST, 0, 7'b0000000);
    add_row(3'b000, 7'b0010000, 3'b101, NO_MST, 0, 7'b0000000);
    add_row(3'b000, 7'b0010000, 3'b101, 1,      4, 7'b0000000);
    add_row(3'b000, 7'b0010000, 3'b101, 1,      4, 7'b0000000);
    add_row(3'b000, 7'b0010000, 3'b111, 1,      4, 7'b0010000);
    add_row(3'b000, 7'b0000000, 3'b111, NO_MST, 0, 7'b0000000);
    // Four bursts, slaves 1, 3, 6 then wrap to 0
    add_row(3'b111, 7'b0000000, 3'b111, NO_MST, 0, 7'b0000000);
    add_row(3'b001, 7'b1001010, 3'b111, NO_MST, 0, 7'b0000000);
    add_row(3'b000, 7'b1001010, 3'b111, 1,      1, 7'b0000010);
    add_row(3'b000, 7'b1001001, 3'b111, 0,      3, 7'b0001000);
    add_row(3'b000, 7'b1000001, 3'b111, 2,      6, 7'b1000000);
    add_row(3'b000, 7'b0000001, 3'b111, 0,      0, 7'b0000001);
    add_row(3'b000, 7'b0000000, 3'b111, NO_MST, 0, 7'b0000000);
    // Slave 5 has no master, dropped even with every bready low
    add_row(3'b100, 7'b0100000, 3'b111, NO_MST, 0, 7'b0000000);
    add_row(3'b000, 7'b0100000, 3'b111, NO_MST, 0, 7'b0000000);
    add_row(3'b000, 7'b0100000, 3'b000, NO_MST, 0, 7'b0100000);
    add_row(3'b000, 7'b0000100, 3'b111, NO_MST, 0, 7'b0000000);
    add_row(3'b000, 7'b0000100, 3'b111, NO_MST, 0, 7'b0000000);
    add_row(3'b010, 7'b0000100, 3'b111, NO_MST, 0, 7'b0000000);
    add_row(3'b000, 7'b0000100, 3'b111, NO_MST, 0, 7'b0000000);
    add_row(3'b000, 7'b0000100, 3'b111, 2,      2, 7'b0000100);
    add_row(3'b000, 7'b0000000, 3'b111, NO_MST, 0, 7'b0000000);
  endtask

  task automatic drive_step(input step_t st);
    wvalid_m <= st.wdone;
    wready_m <= st.wdone;
    wlast_m  <= st.wdone;
    bvalid_s <= st.bvalid;
    bready_m <= st.bready;
  endtask

  task automatic check_step(input int idx, input step_t st);
    logic [`AXI_NUM_MST-1:0] exp_valid;
    exp_valid = '0;
    if (st.exp_mst < NO_MST) begin
      exp_valid[st.exp_mst] = 1'b1;
    end
    check_valid("bvalid_m", idx, exp_valid, bvalid_m);
    check_ready("bready_s", idx, st.exp_rdy, bready_s);
    if (st.exp_mst < NO_MST) begin
      // Master field stripped from the slave's ID
      check_id($sformatf("bid_m[%0d]", st.exp_mst), idx,
               slv_id[st.exp_slv].fld.id, bid_m[st.exp_mst]);
      check_resp($sformatf("bresp_m[%0d]", st.exp_mst), idx, slv_resp[st.exp_slv],
                 axi_b_pkg::b_resp_e'(bresp_m[st.exp_mst]));
    end
  endtask

  initial begin
    rstn     = 1'b0;
    bready_m = '0;
    wvalid_m = '0;
    wready_m = '0;
    wlast_m  = '0;
    bvalid_s = '0;
    build_slaves();
    build_steps();
    cycle_limit = steps.size() * 8 + 50;

    // Traffic during reset must be ignored
    repeat (5) begin
      @(posedge clk);
      wvalid_m <= '1;
      wready_m <= '1;
      wlast_m  <= '1;
      bvalid_s <= '1;
      bready_m <= '1;
      @(negedge clk);
      check_valid("bvalid_m", -1, '0, bvalid_m);
      check_ready("bready_s", -1, '0, bready_s);
    end
    @(posedge clk);
    rstn     <= 1'b1;
    wvalid_m <= '0;
    wready_m <= '0;
    wlast_m  <= '0;
    bvalid_s <= '0;
    @(negedge clk);
    check_valid("bvalid_m", -1, '0, bvalid_m);
    check_ready("bready_s", -1, '0, bready_s);

    for (int idx = 0; idx < steps.size(); idx++) begin
      @(posedge clk);
      drive_step(steps[idx]);
      @(negedge clk);  // Outputs settled
      check_step(idx, steps[idx]);
    end

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+common
common/axi_b_pkg.sv
hw/b_channel/b_pending_counter.sv
hw/b_channel/b_arb_fsm.sv
hw/b_channel/b_resp_mux.sv
hw/b_channel/b_master_route.sv
hw/b_channel/b_channel.sv
verif/tb_b_channel.sv

/* Bender.yml */
package:
  name: b_channel

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/axi_b_pkg.sv
      - hw/b_channel/b_pending_counter.sv
      - hw/b_channel/b_arb_fsm.sv
      - hw/b_channel/b_resp_mux.sv
      - hw/b_channel/b_master_route.sv
      - hw/b_channel/b_channel.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/tb_b_channel.sv
